// ==== rtl/hist_pkg.sv ====
// histogram transfer definitions
package hist_pkg;

    localparam int num_sensors     = 4;      // sensor ports
    localparam int frame_bits      = 4;      // frame number width
    localparam int page_words      = 256;    // one colour burst per page
    localparam int num_pages       = 4;      // pages in the buffer
    localparam int burst_words     = 16;     // words per axi burst
    localparam int bursts_per_page = page_words / burst_words;

    localparam logic [3:0] axi_len        = 4'hf;  // 16 beats
    localparam logic [1:0] axi_size       = 2'h2;  // 4 bytes per beat
    localparam logic [1:0] axi_burst_type = 2'h1;  // incrementing
    localparam logic [3:0] axi_strb       = 4'hf;  // all bytes

    localparam int mode_bits        = 8;     // mode register width
    localparam int mode_en_bit      = 0;
    localparam int mode_nreset_bit  = 1;     // release from soft reset
    localparam int mode_confirm_bit = 2;     // wait for write responses
    localparam int mode_cache_lsb   = 4;     // awcache field

    typedef logic [31:0]                    hist_word_t;
    typedef logic [frame_bits-1:0]          frame_t;
    typedef logic [1:0]                     color_t;
    typedef logic [1:0]                     sensor_t;
    typedef logic [1:0]                     subchn_t;
    typedef logic [3:0]                     chan_t;       // {sensor, sub-channel}
    typedef logic [$clog2(num_pages)-1:0]   page_t;
    typedef logic [$clog2(page_words)-1:0]  word_addr_t;
    typedef logic [19:0]                    start_page_t; // 4 KB page number
    typedef logic [31:0]                    axi_addr_t;
    typedef logic [5:0]                     axi_id_t;
    typedef logic [3:0]                     cache_t;

    typedef struct packed {
        logic       req;       // held until the histogram is done
        subchn_t    subchn;
        frame_t     frame;
        logic       dvalid;    // 256 cycles per colour burst
        hist_word_t data;
    } sensor_in_t;

    typedef struct packed {
        sensor_t sensor;
        subchn_t subchn;
        frame_t  frame;
        color_t  color;
    } page_attr_t;

    typedef struct packed {
        logic       we;        // single-cycle strobe
        logic       sel_table; // 1 = start-page table, 0 = mode register
        chan_t      idx;       // table entry
        hist_word_t data;
    } cfg_wr_t;

    typedef enum logic [2:0] {
        wr_idle,
        wr_load_attr,
        wr_load_page,
        wr_calc_addr,
        wr_run
    } wr_state_t;

endpackage

// ==== rtl/hist_cfg_regs.sv ====
// configuration registers
`timescale 1ns/1ps
module hist_cfg_regs (
    input  logic                   mclk,
    input  logic                   rst,
    input  hist_pkg::cfg_wr_t      cfg,
    output logic                   en,
    output logic                   confirm,
    output hist_pkg::cache_t       cache,
    input  hist_pkg::chan_t        lookup_chn,
    output hist_pkg::start_page_t  lookup_page
);
    import hist_pkg::*;

    logic [mode_bits-1:0] mode;           // enable, nreset, confirm, cache
    start_page_t          page_tbl [16];  // per-channel start page

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            mode <= '0;                   // comes up disabled
        end else if (cfg.we && !cfg.sel_table) begin
            mode <= cfg.data[mode_bits-1:0];
        end
    end

    always_ff @(posedge mclk) begin
        if (cfg.we && cfg.sel_table) begin
            page_tbl[cfg.idx] <= cfg.data[19:0];
        end
        lookup_page <= page_tbl[lookup_chn];  // one cycle read
    end

    // both bits needed to run, either one clears the datapath
    assign en      = mode[mode_en_bit] & mode[mode_nreset_bit];
    assign confirm = mode[mode_confirm_bit];
    assign cache   = mode[mode_cache_lsb +: 4];

endmodule

// ==== rtl/hist_sensor_arbiter.sv ====
// sensor arbiter and page write
`timescale 1ns/1ps
module hist_sensor_arbiter (
    input  logic                             mclk,
    input  logic                             rst,
    input  logic                             en,
    input  hist_pkg::sensor_in_t             sensors [hist_pkg::num_sensors],
    output logic [hist_pkg::num_sensors-1:0] grant,
    input  logic                             buf_full,
    output logic                             wr_en,
    output hist_pkg::page_t                  wr_page,
    output hist_pkg::word_addr_t             wr_addr,
    output hist_pkg::hist_word_t             wr_data,
    output logic                             page_done,
    output hist_pkg::page_attr_t             attr
);
    import hist_pkg::*;

    logic                   any_req;   // some sensor asks
    sensor_t                enc;       // lowest-numbered requester
    sensor_t                sel;       // sensor being served
    sensor_t                cur;
    logic                   busy;      // holding one sensor for 4 colours
    color_t                 color;
    logic                   dv_in;
    logic                   closing;   // page ended but not counted yet
    logic [num_sensors-1:0] grant_d;

    always_comb begin
        any_req = 1'b0;
        enc     = '0;
        for (int i = num_sensors - 1; i >= 0; i--) begin
            if (sensors[i].req) begin
                any_req = 1'b1;
                enc     = sensor_t'(i);
            end
        end
    end

    assign cur     = busy ? sel : enc;
    assign dv_in   = busy && sensors[sel].dvalid;
    assign closing = (wr_en && !dv_in) || page_done;  // covers count update lag

    always_comb begin
        grant_d = '0;
        if (sensors[cur].req && !buf_full && !closing) begin
            grant_d[cur] = 1'b1;
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            sel       <= '0;
            color     <= '0;
            grant     <= '0;
            wr_en     <= 1'b0;
            wr_page   <= '0;
            page_done <= 1'b0;
        end else if (!en) begin               // flush on disable
            busy      <= 1'b0;
            color     <= '0;
            grant     <= '0;
            wr_en     <= 1'b0;
            wr_page   <= '0;
            page_done <= 1'b0;
        end else begin
            grant     <= grant_d;
            wr_en     <= dv_in;
            page_done <= wr_en && !dv_in;     // falling edge of data-valid
            if (!busy && any_req) begin
                busy <= 1'b1;
                sel  <= enc;
            end
            if (page_done) begin
                color   <= color + 1'b1;      // wraps to 0 after colour 3
                wr_page <= wr_page + 1'b1;
                if (color == 2'd3) begin
                    busy <= 1'b0;             // full histogram taken
                end
            end
        end
    end

    always_ff @(posedge mclk) begin
        wr_data <= sensors[sel].data;
        wr_addr <= wr_en ? wr_addr + 1'b1 : '0;
        if (dv_in && !wr_en) begin            // attributes at burst start
            attr <= '{sensor: sel, subchn: sensors[sel].subchn,
                      frame: sensors[sel].frame, color: color};
        end
    end

endmodule

// ==== rtl/hist_page_buffer.sv ====
// four-page histogram buffer
`timescale 1ns/1ps
module hist_page_buffer (
    input  logic                  mclk,
    input  logic                  rst,
    input  logic                  en,
    input  logic                  wr_en,
    input  hist_pkg::page_t       wr_page,
    input  hist_pkg::word_addr_t  wr_addr,
    input  hist_pkg::hist_word_t  wr_data,
    input  logic                  page_done,
    input  hist_pkg::page_attr_t  attr_in,
    input  logic                  rd_en,
    input  hist_pkg::page_t       rd_page,
    input  hist_pkg::word_addr_t  rd_addr,
    output hist_pkg::hist_word_t  rd_data,
    output hist_pkg::page_attr_t  attr_out,
    input  logic                  page_freed,
    output logic                  buf_full,
    output logic                  buf_empty
);
    import hist_pkg::*;

    typedef logic [$clog2(num_pages):0] count_t;  // 0..4

    hist_word_t mem [num_pages * page_words];
    page_attr_t attr_mem [num_pages];             // one entry per page
    hist_word_t rd_q;                             // first read stage
    count_t     pages;                            // written, not yet freed

    always_ff @(posedge mclk) begin
        if (wr_en) begin
            mem[{wr_page, wr_addr}] <= wr_data;
        end
        if (rd_en) begin
            rd_q <= mem[{rd_page, rd_addr}];
        end
        rd_data <= rd_q;                          // output register stage
        if (page_done) begin
            attr_mem[wr_page] <= attr_in;
        end
    end

    assign attr_out = attr_mem[rd_page];

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            pages <= '0;
        end else if (!en) begin
            pages <= '0;
        end else if (page_done && !page_freed) begin
            pages <= pages + 1'b1;
        end else if (page_freed && !page_done) begin
            pages <= pages - 1'b1;
        end
    end

    assign buf_full  = (pages == count_t'(num_pages));
    assign buf_empty = (pages == '0);

endmodule

// ==== rtl/hist_axi_writer.sv ====
// page reader and axi write master
`timescale 1ns/1ps
module hist_axi_writer (
    input  logic                  mclk,
    input  logic                  rst,
    input  logic                  en,
    input  logic                  confirm,
    input  hist_pkg::cache_t      cache,
    input  logic                  buf_empty,
    input  hist_pkg::page_attr_t  attr,
    output hist_pkg::chan_t       lookup_chn,
    input  hist_pkg::start_page_t lookup_page,
    output logic                  rd_en,
    output hist_pkg::page_t       rd_page,
    output hist_pkg::word_addr_t  rd_addr,
    input  hist_pkg::hist_word_t  rd_data,
    output logic                  page_freed,
    output hist_pkg::axi_addr_t   awaddr,
    output logic                  awvalid,
    input  logic                  awready,
    output hist_pkg::axi_id_t     awid,
    output hist_pkg::cache_t      awcache,
    output logic [3:0]            awlen,
    output logic [1:0]            awsize,
    output logic [1:0]            awburst,
    output hist_pkg::hist_word_t  wdata,
    output logic                  wvalid,
    input  logic                  wready,
    output logic                  wlast,
    output hist_pkg::axi_id_t     wid,
    output logic [3:0]            wstrb,
    input  logic                  bvalid,
    output logic                  bready
);
    import hist_pkg::*;

    localparam int wcnt_bits = $clog2(burst_words);
    typedef logic [$clog2(bursts_per_page):0] bcnt_t;  // 0..16

    wr_state_t             state;
    page_attr_t            attr_r;      // attributes of the page being sent
    logic                  confirm_r;   // mode sampled per block
    logic [25:0]           addr_hi;     // awaddr[31:6]
    bcnt_t                 aw_left;     // address bursts still to issue
    bcnt_t                 w_left;      // data bursts still to send
    bcnt_t                 b_left;      // responses still expected
    logic                  rd_run;      // page read in progress
    logic [1:0]            rd_pipe;     // buffer read latency
    hist_word_t            fifo [4];
    logic [1:0]            fifo_wp;
    logic [1:0]            fifo_rp;
    logic [2:0]            fifo_cnt;
    logic                  fifo_half;
    logic                  fifo_re;
    logic [wcnt_bits-1:0]  wcnt;        // beat within the burst
    logic                  block_end;

    assign lookup_chn = {attr_r.sensor, attr_r.subchn};
    assign awaddr     = {addr_hi, 6'b0};
    assign awvalid    = (state == wr_run) && (aw_left != '0);
    assign awid       = {attr_r.sensor, attr_r.subchn, attr_r.color};
    assign awcache    = cache;
    assign awlen      = axi_len;
    assign awsize     = axi_size;
    assign awburst    = axi_burst_type;
    assign wid        = awid;
    assign wstrb      = axi_strb;
    assign bready     = 1'b1;

    assign wvalid    = (fifo_cnt != '0);
    assign wdata     = fifo[fifo_rp];
    assign fifo_re   = wvalid && wready;
    assign wlast     = (wcnt == wcnt_bits'(burst_words - 1));
    assign fifo_half = fifo_cnt[2] || fifo_cnt[1];   // 2 or more, leaves room for 2 in flight
    assign rd_en     = rd_run && !fifo_half;

    // all bursts issued, then data or responses done depending on mode
    assign block_end  = (state == wr_run) && (aw_left == '0)
                        && (confirm_r ? (b_left == '0) : (w_left == '0));
    assign page_freed = block_end;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst || !en) begin
            state     <= wr_idle;
            confirm_r <= 1'b0;
            rd_page   <= '0;
            aw_left   <= '0;
            w_left    <= '0;
            b_left    <= '0;
            rd_run    <= 1'b0;
            rd_pipe   <= '0;
            fifo_wp   <= '0;
            fifo_rp   <= '0;
            fifo_cnt  <= '0;
            wcnt      <= '0;
        end else begin
            rd_pipe  <= {rd_pipe[0], rd_en};
            fifo_cnt <= fifo_cnt + 3'(rd_pipe[1]) - 3'(fifo_re);
            if (rd_pipe[1]) fifo_wp <= fifo_wp + 1'b1;
            if (fifo_re) begin
                fifo_rp <= fifo_rp + 1'b1;
                wcnt    <= wcnt + 1'b1;
            end
            if (awvalid && awready) aw_left <= aw_left - 1'b1;
            if (fifo_re && wlast && w_left != '0) w_left <= w_left - 1'b1;
            if (bvalid && b_left != '0) b_left <= b_left - 1'b1;   // ignore strays
            if (rd_en && rd_addr == word_addr_t'(page_words - 1)) rd_run <= 1'b0;
            case (state)                      // block loads override the counts above
                wr_idle:      if (!buf_empty) state <= wr_load_attr;
                wr_load_attr: begin
                    state     <= wr_load_page;
                    confirm_r <= confirm;
                end
                wr_load_page: state <= wr_calc_addr;   // table read in flight
                wr_calc_addr: begin
                    state   <= wr_run;
                    aw_left <= bcnt_t'(bursts_per_page);
                    w_left  <= bcnt_t'(bursts_per_page);
                    b_left  <= bcnt_t'(bursts_per_page);
                    rd_run  <= 1'b1;
                end
                wr_run: if (block_end) begin
                    state   <= wr_idle;
                    rd_page <= rd_page + 1'b1;
                end
                default: state <= wr_idle;
            endcase
        end
    end

    always_ff @(posedge mclk) begin
        if (rd_pipe[1]) fifo[fifo_wp] <= rd_data;
        if (state == wr_load_attr) attr_r <= attr;
        if (state == wr_calc_addr) begin
            // start page + frame at 4 KB, colour at 1 KB, burst at 64 B
            addr_hi <= {lookup_page + start_page_t'(attr_r.frame), attr_r.color, 4'b0};
            rd_addr <= '0;
        end else begin
            if (awvalid && awready) addr_hi <= addr_hi + 1'b1;
            if (rd_en) rd_addr <= rd_addr + 1'b1;
        end
    end

endmodule

// ==== rtl/hist_saxi_top.sv ====
// histogram to axi top level
`timescale 1ns/1ps
module hist_saxi_top (
    input  logic                             mclk,
    input  logic                             rst,
    input  hist_pkg::cfg_wr_t                cfg,
    input  hist_pkg::sensor_in_t             sensors [hist_pkg::num_sensors],
    output logic [hist_pkg::num_sensors-1:0] grant,
    output hist_pkg::axi_addr_t              awaddr,
    output logic                             awvalid,
    input  logic                             awready,
    output hist_pkg::axi_id_t                awid,
    output hist_pkg::cache_t                 awcache,
    output logic [3:0]                       awlen,
    output logic [1:0]                       awsize,
    output logic [1:0]                       awburst,
    output hist_pkg::hist_word_t             wdata,
    output logic                             wvalid,
    input  logic                             wready,
    output logic                             wlast,
    output hist_pkg::axi_id_t                wid,
    output logic [3:0]                       wstrb,
    input  logic                             bvalid,
    output logic                             bready
);
    import hist_pkg::*;

    logic        en, confirm, buf_full, buf_empty;
    cache_t      cache;
    chan_t       lookup_chn;
    start_page_t lookup_page;
    logic        wr_en, page_done, rd_en, page_freed;
    page_t       wr_page, rd_page;
    word_addr_t  wr_addr, rd_addr;
    hist_word_t  wr_data, rd_data;
    page_attr_t  wr_attr, rd_attr;   // into and out of the attribute store

    hist_cfg_regs cfg_regs_i (.mclk, .rst, .cfg, .en, .confirm, .cache,
                              .lookup_chn, .lookup_page);

    hist_sensor_arbiter arbiter_i (.mclk, .rst, .en, .sensors, .grant, .buf_full,
                                   .wr_en, .wr_page, .wr_addr, .wr_data, .page_done,
                                   .attr(wr_attr));

    hist_page_buffer buffer_i (.mclk, .rst, .en, .wr_en, .wr_page, .wr_addr, .wr_data,
                               .page_done, .attr_in(wr_attr), .rd_en, .rd_page, .rd_addr,
                               .rd_data, .attr_out(rd_attr), .page_freed, .buf_full,
                               .buf_empty);

    hist_axi_writer writer_i (.mclk, .rst, .en, .confirm, .cache, .buf_empty,
                              .attr(rd_attr), .lookup_chn, .lookup_page, .rd_en, .rd_page,
                              .rd_addr, .rd_data, .page_freed, .awaddr, .awvalid, .awready,
                              .awid, .awcache, .awlen, .awsize, .awburst, .wdata, .wvalid,
                              .wready, .wlast, .wid, .wstrb, .bvalid, .bready);

endmodule

// ==== bench/hist_saxi_assert.sv ====
// axi protocol checks
`timescale 1ns/1ps
module hist_saxi_assert (
    input logic                             mclk,
    input logic                             rst,
    input logic                             en,
    input logic                             buf_full,
    input logic [hist_pkg::num_sensors-1:0] grant,
    input hist_pkg::axi_addr_t              awaddr,
    input logic                             awvalid,
    input logic                             awready,
    input hist_pkg::axi_id_t                awid,
    input hist_pkg::hist_word_t             wdata,
    input logic                             wvalid,
    input logic                             wready,
    input logic                             wlast
);
    import hist_pkg::*;

    int unsigned fail_count = 0;  // number of failed assertions

    aw_hold: assert property (@(posedge mclk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awid))
        else begin
            $error("awvalid dropped or address changed before awready");
            fail_count++;
        end

    w_hold: assert property (@(posedge mclk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
        else begin
            $error("wvalid dropped or data changed before wready");
            fail_count++;
        end

    grant_off: assert property (@(posedge mclk) disable iff (rst)
        !en |=> grant == '0)              // grant is registered so it lags by one cycle
        else begin
            $error("grant raised while the design is disabled");
            fail_count++;
        end

    grant_full: assert property (@(posedge mclk) disable iff (rst)
        buf_full |=> grant == '0)
        else begin
            $error("grant raised while four pages wait");
            fail_count++;
        end

endmodule

bind hist_saxi_top hist_saxi_assert assert_i (
    .mclk, .rst, .en, .buf_full, .grant, .awaddr, .awvalid, .awready, .awid,
    .wdata, .wvalid, .wready, .wlast
);

// ==== bench/tb_hist_saxi.sv ====
// histogram transfer testbench
`timescale 1ns/1ps
module tb_hist_saxi;
    import hist_pkg::*;

    localparam int total_words     = 8 * num_pages * page_words;  // 8 histograms over all tests
    localparam int cycles_per_word = 40;

    logic                   mclk;
    logic                   rst;
    cfg_wr_t                cfg;
    sensor_in_t             sensors [num_sensors];
    logic [num_sensors-1:0] grant;
    axi_addr_t              awaddr;
    logic                   awvalid;
    logic                   awready;
    axi_id_t                awid;
    cache_t                 awcache;
    logic [3:0]             awlen;
    logic [1:0]             awsize;
    logic [1:0]             awburst;
    hist_word_t             wdata;
    logic                   wvalid;
    logic                   wready;
    logic                   wlast;
    axi_id_t                wid;
    logic [3:0]             wstrb;
    logic                   bvalid;
    logic                   bready;

    logic [31:0]  data_rng = 32'h1889;  // sensor words
    logic [31:0]  rdy_rng  = 32'h1889;  // ready and response timing
    int unsigned  ready_pct = 100;
    int unsigned  resp_min  = 1;
    int unsigned  resp_span = 4;
    start_page_t  tbl [16];             // copy of the start-page table
    axi_addr_t    exp_addr [$];
    axi_id_t      exp_id [$];
    axi_id_t      exp_wid [$];          // one entry per data burst
    hist_word_t   exp_data [$];
    int unsigned  resp_due [$];         // cycle at which each response is due
    sensor_t      serve_log [$];        // sensor of each burst, in grant order
    int unsigned  cycle = 0;
    int unsigned  w_beats = 0;
    int unsigned  aw_count = 0;
    int unsigned  b_count = 0;
    int           pages_started = 0;
    int           pages_drained = 0;
    int           errors = 0;
    int           test_base = 0;
    int           tests_run = 0;
    int           tests_failed = 0;
    cache_t       exp_cache = '0;
    logic         confirm_on = 1'b0;
    logic         full_seen = 1'b0;
    string        test_name = "reset";

    hist_saxi_top dut_i (.mclk, .rst, .cfg, .sensors, .grant, .awaddr, .awvalid, .awready,
                         .awid, .awcache, .awlen, .awsize, .awburst, .wdata, .wvalid,
                         .wready, .wlast, .wid, .wstrb, .bvalid, .bready);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s: %s", test_name, msg);
        errors++;
    endtask

    initial mclk = 1'b0;
    always #4 mclk = ~mclk;

    // axi slave model driving 1 ns after the edge
    always begin
        @(posedge mclk);
        #1;
        cycle++;
        rdy_rng = lcg_next(rdy_rng);
        awready = (rdy_rng[31:16] % 100) < ready_pct;
        rdy_rng = lcg_next(rdy_rng);
        wready  = (rdy_rng[31:16] % 100) < ready_pct;
        bvalid  = 1'b0;
        if (resp_due.size() != 0 && resp_due[0] <= cycle) begin
            bvalid = 1'b1;                 // bready is tied high
            void'(resp_due.pop_front());
        end
    end

    task automatic check_aw();
        if (exp_addr.size() == 0) begin
            report_failure("address burst issued with no data sent for it");
        end else begin
            check_value("awaddr", exp_addr.pop_front(), awaddr);
            check_value("awid", 32'(exp_id.pop_front()), 32'(awid));
            check_value("awcache", 32'(exp_cache), 32'(awcache));
            check_value("awlen", 32'd15, 32'(awlen));      // 16 beats
            check_value("awsize", 32'd2, 32'(awsize));     // 4 bytes per beat
            check_value("awburst", 32'd1, 32'(awburst));   // incrementing
            // next block only after every response of the ones before
            if (confirm_on && aw_count % bursts_per_page == 0 && b_count < aw_count) begin
                check_value("responses before block start", aw_count, b_count);
            end
        end
        aw_count++;
    endtask

    task automatic check_w();
        logic exp_last;
        exp_last = (w_beats % burst_words) == burst_words - 1;
        if (exp_data.size() == 0) begin
            report_failure("data beat sent with no word written for it");
        end else begin
            check_value("wdata", exp_data.pop_front(), wdata);
            check_value("wid", 32'(exp_wid[0]), 32'(wid));
            if (exp_last) void'(exp_wid.pop_front());
        end
        check_value("wlast", 32'(exp_last), 32'(wlast));
        check_value("wstrb", 32'hf, 32'(wstrb));           // all byte lanes
        if (wlast) begin
            rdy_rng = lcg_next(rdy_rng);
            resp_due.push_back(cycle + resp_min + rdy_rng[31:16] % resp_span);
        end
        w_beats++;
        if (w_beats % page_words == 0) pages_drained++;
    endtask

    // outputs are stable at the falling edge
    always @(negedge mclk) begin
        if (!rst) begin
            if (awvalid && awready) check_aw();
            if (wvalid && wready) check_w();
            if (bvalid) begin
                check_value("bready", 32'd1, 32'(bready));
                b_count++;
            end
            if (dut_i.buf_full) full_seen = 1'b1;
        end
    end

    task automatic write_cfg(input logic sel, input chan_t idx, input hist_word_t data);
        cfg = '{we: 1'b1, sel_table: sel, idx: idx, data: data};
        @(posedge mclk);
        #1;
        cfg.we = 1'b0;
    endtask

    task automatic set_mode(input logic run, input logic conf, input cache_t cache);
        hist_word_t word;
        word                      = '0;
        word[mode_en_bit]         = run;
        word[mode_nreset_bit]     = 1'b1;
        word[mode_confirm_bit]    = conf;
        word[mode_cache_lsb +: 4] = cache;
        exp_cache  = cache;
        confirm_on = conf;
        write_cfg(1'b0, '0, word);
    endtask

    // four colour bursts that each start only under grant
    task automatic send_histogram(input int s, input subchn_t sc, input frame_t fr);
        chan_t     chn;
        axi_addr_t base;
        chn = chan_t'({s[1:0], sc});
        sensors[s].subchn = sc;
        sensors[s].frame  = fr;
        sensors[s].req    = 1'b1;
        for (int c = 0; c < num_pages; c++) begin
            do begin
                @(posedge mclk);
                #1;
            end while (!grant[s]);
            pages_started++;
            if (pages_started - pages_drained > num_pages) begin
                report_failure("a fifth unsent page was started");
            end
            serve_log.push_back(sensor_t'(s));
            base = (axi_addr_t'(tbl[chn]) + axi_addr_t'(fr)) << 12;  // 4 KB pages
            base = base + (axi_addr_t'(c) << 10);                     // colour at 1 KB
            for (int b = 0; b < bursts_per_page; b++) begin
                exp_addr.push_back(base + axi_addr_t'(b * 64));
                exp_id.push_back({sensor_t'(s), sc, color_t'(c)});
                exp_wid.push_back({sensor_t'(s), sc, color_t'(c)});
            end
            for (int w = 0; w < page_words; w++) begin
                data_rng = lcg_next(data_rng);
                sensors[s].dvalid = 1'b1;
                sensors[s].data   = data_rng;
                exp_data.push_back(data_rng);
                @(posedge mclk);
                #1;
            end
            sensors[s].dvalid = 1'b0;
        end
        sensors[s].req = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_data.size() != 0 || exp_addr.size() != 0 || resp_due.size() != 0) begin
            @(posedge mclk);
        end
        repeat (8) @(posedge mclk);
        #1;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_base = errors + int'(dut_i.assert_i.fail_count);
    endtask

    task automatic finish_test();
        int failed;
        failed = errors + int'(dut_i.assert_i.fail_count) - test_base;
        tests_run++;
        if (failed != 0) tests_failed++;
        $display("test %0d %s: %0d errors", tests_run, test_name, failed);
    endtask

    initial begin
        int total;
        rst     = 1'b1;
        cfg     = '0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        for (int i = 0; i < num_sensors; i++) sensors[i] = '0;
        repeat (3) @(posedge mclk);
        #1;
        rst = 1'b0;
        repeat (2) @(posedge mclk);
        #1;
        for (int i = 0; i < 16; i++) begin
            tbl[i] = start_page_t'(20'h80000 + i * 64);
            write_cfg(1'b1, chan_t'(i), hist_word_t'(tbl[i]));
        end

        begin_test("single_histogram");
        ready_pct = 70;
        set_mode(1'b1, 1'b0, 4'h3);
        send_histogram(3, 2'd2, 4'd5);
        wait_drained();
        finish_test();

        begin_test("priority_0_over_2");
        serve_log.delete();
        fork
            send_histogram(2, 2'd1, 4'd9);
            send_histogram(0, 2'd3, 4'd2);
        join
        wait_drained();
        for (int i = 0; i < serve_log.size(); i++) begin
            check_value("served sensor", (i < 4) ? 0 : 2, 32'(serve_log[i]));
        end
        finish_test();

        begin_test("back_pressure");
        ready_pct = 25;                   // writer far slower than sensors
        full_seen = 1'b0;
        fork
            begin
                send_histogram(1, 2'd0, 4'd3);
                send_histogram(1, 2'd0, 4'd4);
            end
            send_histogram(3, 2'd1, 4'd11);
        join
        wait_drained();
        if (!full_seen) report_failure("buffer never filled, grant gating not reached");
        finish_test();

        begin_test("confirm_mode");
        ready_pct = 60;
        resp_min  = 10;                   // responses well behind the data
        resp_span = 32;
        set_mode(1'b1, 1'b1, 4'ha);
        send_histogram(2, 2'd0, 4'd15);
        wait_drained();
        finish_test();

        begin_test("disabled");
        ready_pct = 100;
        resp_min  = 1;
        resp_span = 4;
        set_mode(1'b0, 1'b0, 4'h3);
        fork
            send_histogram(1, 2'd1, 4'd7);
            begin
                repeat (60) begin
                    @(negedge mclk);
                    if (grant != '0 || awvalid || wvalid) begin
                        report_failure("grant or axi activity while disabled");
                    end
                end
                @(posedge mclk);
                #1;
                set_mode(1'b1, 1'b0, 4'h3);
            end
        join
        wait_drained();
        finish_test();

        total = errors + int'(dut_i.assert_i.fail_count);
        $display("%0d tests, %0d with errors, %0d errors in total",
                 tests_run, tests_failed, total);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        repeat (total_words * cycles_per_word) @(posedge mclk);
        $display("timeout: run did not finish within %0d cycles",
                 total_words * cycles_per_word);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== files.f ====
rtl/hist_pkg.sv
rtl/hist_cfg_regs.sv
rtl/hist_sensor_arbiter.sv
rtl/hist_page_buffer.sv
rtl/hist_axi_writer.sv
rtl/hist_saxi_top.sv
bench/hist_saxi_assert.sv
bench/tb_hist_saxi.sv

// ==== run.sh ====
#!/bin/sh
# build and run the histogram testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_hist_saxi \
    -f files.f -Mdir obj_dir -o sim
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

# raise the error limit so assertion failures reach the final report
out=$(./obj_dir/sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
